// ==== verilog/intr_types_pkg.sv ====
package intr_types_pkg;

  // Request side sizes for the interrupt vector generator.
  localparam int num_req    = 16;  // total request lines, 15 down to 0.
  localparam int group_size = 8;   // lines per priority group.
  localparam int vec_w      = 3;   // width of a line index within a group.

  // One bit per request line, active high.
  typedef logic [num_req-1:0] req_t;  // full request word, bit n is line n.

  // Half of the request word, as seen by one encoder.
  typedef logic [group_size-1:0] group_req_t;  // bit 7 has the highest priority.

  // Line index within a group.
  typedef logic [vec_w-1:0] vec_t;  // 7 is the highest line of the group.

  // Encoder result and held copy of it.
  typedef struct packed {
    logic det;  // at least one line of the group is pending.
    vec_t vec;  // index of the highest pending line, zero when det is low.
  } held_vec_t;

  // The encoder and the hold register both rely on these widths lining up.
  // A group must fit its index in vec_w bits.
  // The high and low groups together cover the whole request word.

endpackage

// ==== verilog/intr_bus_pkg.sv ====
package intr_bus_pkg;

  // Which of the two status registers a bus access or read points at.
  typedef enum logic {
    sel_lo = 1'b0,  // low group, lines 7 to 0.
    sel_hi = 1'b1   // high group, lines 15 to 8.
  } group_sel_t;

  // Status register of one group, as seen by the CPU.
  typedef struct packed {
    logic                 enable;  // group may raise its above flag.
    intr_types_pkg::vec_t level;   // current level, only higher vectors pass.
  } level_reg_t;

  // Write strobe with target and data, all in one cycle.
  typedef struct packed {
    logic       wr;    // write strobe, acted on at the next rising edge.
    group_sel_t sel;   // target status register.
    level_reg_t data;  // new enable and level.
  } bus_wr_t;

  // A read returns a level_reg_t, so the read data word has the same
  // layout as the register and needs no type of its own.
  // The bus decoder that builds bus_wr_t lives outside this block.
  // Bit order of level_reg_t is enable on top, level below it.

endpackage

// ==== verilog/req_priority.sv ====
`timescale 1ns/10ps

module req_priority (
  input  intr_types_pkg::group_req_t req,  // eight request lines of one group.
  output intr_types_pkg::held_vec_t  held  // detect flag and winning index.
);

  import intr_types_pkg::*;

  // Scan from the top line down, the first set bit wins.
  always_comb begin
    held = '0;  // nothing pending gives det low and a zero vector.
    for (int i = group_size - 1; i >= 0; i--) begin
      if (req[i] && !held.det) begin  // first hit seen from the top.
        held.det = 1'b1;              // mark the group as pending.
        held.vec = vec_t'(i);         // index of the highest pending line.
      end
    end
  end

  // A detected vector must point at a set line with nothing set above it.
  // The shift drops all lines below vec, so only bit 0 may remain.
  always_comb begin
    if (held.det) begin
      assert final ((req >> held.vec) == group_req_t'(1))  // winner is the highest line.
      else $error("encoder picked line %0d for request %b", held.vec, req);
    end else begin
      assert final (req == '0)  // det low only for an idle group.
      else $error("encoder missed a pending line in request %b", req);
    end
  end

  // The high group instance sees lines 15 to 8 as its bits 7 to 0.
  // The low group instance sees lines 7 to 0 directly.
  // Neither instance knows which group it serves, the top level does.

endmodule

// ==== verilog/vector_hold.sv ====
`timescale 1ns/10ps

module vector_hold (
  input  logic                      mclk,     // system clock.
  input  logic                      reset,    // synchronous, active high.
  input  logic                      sample,   // capture strobe for both groups.
  input  intr_types_pkg::held_vec_t hi_next,  // live encoder result, high group.
  input  intr_types_pkg::held_vec_t lo_next,  // live encoder result, low group.
  output intr_types_pkg::held_vec_t hi_held,  // held result, high group.
  output intr_types_pkg::held_vec_t lo_held   // held result, low group.
);

  // The held vectors stay steady between sample strobes so that an
  // acknowledge in progress is not disturbed by new requests.
  always_ff @(posedge mclk) begin
    if (reset) begin
      hi_held <= '0;  // no pending line after reset.
      lo_held <= '0;  // same for the low group.
    end else if (sample) begin
      hi_held <= hi_next;  // both groups are captured in the same cycle.
      lo_held <= lo_next;  // so the two held values always belong together.
    end
  end

  // The encoder drives a zero vector when nothing is pending, and the
  // hold register must keep that pairing across every capture.
  property p_idle_vec_zero(held_vec_t_det, held_vec_t_vec);
    @(posedge mclk) disable iff (reset)
      !held_vec_t_det |-> (held_vec_t_vec == '0);
  endproperty

  a_hi_idle_vec: assert property (p_idle_vec_zero(hi_held.det, hi_held.vec))
    else $error("high group held vec %0d with det low", hi_held.vec);  // pairing lost.

  a_lo_idle_vec: assert property (p_idle_vec_zero(lo_held.det, lo_held.vec))
    else $error("low group held vec %0d with det low", lo_held.vec);  // pairing lost.

endmodule

// ==== verilog/level_status.sv ====
`timescale 1ns/10ps

module level_status (
  input  intr_types_pkg::held_vec_t hi_held,   // held high group vector.
  input  intr_types_pkg::held_vec_t lo_held,   // held low group vector.
  input  logic                      mclk,      // system clock.
  input  logic                      reset,     // synchronous, active high.
  input  intr_bus_pkg::bus_wr_t     bus_wr,    // CPU write to a status register.
  input  logic                      grant_hi,  // load high level from hi_held.
  input  logic                      grant_lo,  // load low level from lo_held.
  input  logic                      rd_en,     // read enable, gates rd_data.
  input  intr_bus_pkg::group_sel_t  rd_sel,    // register picked by a read.
  output logic                      hi_above,  // high vector beats its level.
  output logic                      lo_above,  // low vector beats its level.
  output intr_bus_pkg::level_reg_t  rd_data    // read data, zero when idle.
);

  import intr_types_pkg::*;
  import intr_bus_pkg::*;

  level_reg_t hi_reg;   // high group status register.
  level_reg_t lo_reg;   // low group status register.
  level_reg_t hi_next;  // next value of the high register.
  level_reg_t lo_next;  // next value of the low register.
  logic       hi_wr;    // bus write hits the high register.
  logic       lo_wr;    // bus write hits the low register.

  // Input source of one status register.
  // A bus write wins over a grant, and a grant keeps the enable bit.
  function automatic level_reg_t pick_next(level_reg_t cur, logic wr_hit,
                                           level_reg_t wr_data, logic grant,
                                           vec_t held_vec);
    level_reg_t nxt;
    nxt = cur;                  // hold the current value by default.
    if (wr_hit) begin
      nxt = wr_data;            // CPU write replaces enable and level.
    end else if (grant) begin
      nxt.level = held_vec;     // acknowledged vector becomes the level.
    end
    return nxt;
  endfunction

  // Held vector is pending, the group is enabled and the vector is higher.
  function automatic logic is_above(held_vec_t held, level_reg_t stat);
    return held.det && stat.enable && (held.vec > stat.level);
  endfunction

  assign hi_wr = bus_wr.wr && (bus_wr.sel == sel_hi);  // address decode, high.
  assign lo_wr = bus_wr.wr && (bus_wr.sel == sel_lo);  // address decode, low.

  assign hi_next = pick_next(hi_reg, hi_wr, bus_wr.data, grant_hi, hi_held.vec);
  assign lo_next = pick_next(lo_reg, lo_wr, bus_wr.data, grant_lo, lo_held.vec);

  always_ff @(posedge mclk) begin
    if (reset) begin
      hi_reg <= '0;  // disabled, level zero.
      lo_reg <= '0;  // disabled, level zero.
    end else begin
      hi_reg <= hi_next;  // write, grant or hold.
      lo_reg <= lo_next;  // write, grant or hold.
    end
  end

  // Compare is combinational from the held vectors and the registers.
  assign hi_above = is_above(hi_held, hi_reg);  // high group request level check.
  assign lo_above = is_above(lo_held, lo_reg);  // low group request level check.

  // Read mux, driven to zero while no read is in progress.
  always_comb begin
    rd_data = '0;  // idle bus reads as zero.
    if (rd_en) begin
      rd_data = (rd_sel == sel_hi) ? hi_reg : lo_reg;  // pick the addressed group.
    end
  end

  // The CPU only acknowledges a group that has a sampled request.
  a_grant_hi_det: assert property (@(posedge mclk) disable iff (reset)
    grant_hi |-> hi_held.det)
    else $error("grant_hi with no held high request");  // acknowledge of nothing.

  a_grant_lo_det: assert property (@(posedge mclk) disable iff (reset)
    grant_lo |-> lo_held.det)
    else $error("grant_lo with no held low request");  // acknowledge of nothing.

  // Readback bus must stay quiet between reads.
  a_rd_idle_zero: assert property (@(posedge mclk) disable iff (reset)
    !rd_en |-> (rd_data == '0))
    else $error("rd_data driven while rd_en is low");  // bus contention risk.

endmodule

// ==== verilog/intr_vecgen.sv ====
`timescale 1ns/10ps

module intr_vecgen (
  input  logic                      mclk,      // system clock.
  input  logic                      reset,     // synchronous, active high.
  input  intr_types_pkg::req_t      req,       // sixteen request lines.
  input  logic                      sample,    // capture strobe for the vectors.
  input  intr_bus_pkg::bus_wr_t     bus_wr,    // CPU write to a status register.
  input  logic                      grant_hi,  // acknowledge of the high group.
  input  logic                      grant_lo,  // acknowledge of the low group.
  input  logic                      rd_en,     // status read enable.
  input  intr_bus_pkg::group_sel_t  rd_sel,    // status register to read.
  output intr_types_pkg::held_vec_t hi_held,   // held high group vector.
  output intr_types_pkg::held_vec_t lo_held,   // held low group vector.
  output logic                      hi_above,  // high group wants service.
  output logic                      lo_above,  // low group wants service.
  output intr_bus_pkg::level_reg_t  rd_data    // status read data.
);

  import intr_types_pkg::*;

  held_vec_t hi_next;  // live encoder output, high group.
  held_vec_t lo_next;  // live encoder output, low group.

  // Lines 15 to 8 form the high group.
  req_priority i_prio_hi (
    .req  (req[num_req-1 -: group_size]),
    .held (hi_next)
  );

  // Lines 7 to 0 form the low group.
  req_priority i_prio_lo (
    .req  (req[group_size-1:0]),
    .held (lo_next)
  );

  // Both groups are captured together on the sample strobe.
  vector_hold i_hold (
    .mclk    (mclk),
    .reset   (reset),
    .sample  (sample),
    .hi_next (hi_next),
    .lo_next (lo_next),
    .hi_held (hi_held),
    .lo_held (lo_held)
  );

  // Status registers, level compare and read port.
  level_status i_status (
    .hi_held  (hi_held),
    .lo_held  (lo_held),
    .mclk     (mclk),
    .reset    (reset),
    .bus_wr   (bus_wr),
    .grant_hi (grant_hi),
    .grant_lo (grant_lo),
    .rd_en    (rd_en),
    .rd_sel   (rd_sel),
    .hi_above (hi_above),
    .lo_above (lo_above),
    .rd_data  (rd_data)
  );

endmodule

// ==== verification/tb_intr_vecgen.sv ====
`timescale 1ns/10ps

module tb_intr_vecgen;

  import intr_types_pkg::*;
  import intr_bus_pkg::*;

  localparam logic [31:0] lfsr_seed  = 32'h006b8254;  // start state of the stimulus LFSR.
  localparam int          wait_limit = 20;            // cycles allowed for any wait.

  logic mclk, reset, sample, grant_hi, grant_lo, rd_en;  // plain DUT controls.
  req_t       req;                                       // request lines.
  bus_wr_t    bus_wr;                                    // CPU write port.
  group_sel_t rd_sel;                                    // read select.
  held_vec_t  hi_held, lo_held;                          // DUT held vectors.
  logic       hi_above, lo_above;                        // DUT compare flags.
  level_reg_t rd_data;                                   // DUT read data.

  held_vec_t  sh_hi_held, sh_lo_held;  // shadow copies of the hold registers.
  level_reg_t sh_hi_reg, sh_lo_reg;    // shadow copies of the status registers.
  logic [31:0] lfsr_state;             // current LFSR state.
  int checks, held_errs, level_errs, flag_errs, timeouts;  // result counters.
  logic det_ok;                        // last det wait succeeded.

  intr_vecgen i_dut (.*);  // port names match the testbench signals.

  initial begin
    mclk = 1'b0;
    forever #5 mclk = ~mclk;  // 10 ns period.
  end

  // Taps of x^32 + x^22 + x^2 + x + 1 with the register shifting toward the top bit.
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Collects n bits, one LFSR step per bit.
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[31]};  // the top bit is the output tap.
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  function automatic req_t rand_req();
    logic [31:0] b;
    b = take_bits(num_req);
    return b[num_req-1:0];
  endfunction

  function automatic level_reg_t rand_level();
    logic [31:0] b;
    b = take_bits(4);
    return b[3:0];
  endfunction

  // Highest set line of a group wins; an upward scan keeps the last hit.
  function automatic held_vec_t ref_encode(group_req_t g);
    held_vec_t r;
    r = '0;
    for (int i = 0; i < group_size; i++) begin
      if (g[i]) begin
        r.det = 1'b1;
        r.vec = i[vec_w-1:0];
      end
    end
    return r;
  endfunction

  function automatic logic ref_above(held_vec_t h, level_reg_t s);
    return h.det & s.enable & (h.vec > s.level);  // pending, enabled and strictly higher.
  endfunction

  function automatic level_reg_t ref_read(logic en, group_sel_t sel);
    if (!en) return '0;                            // idle read port is zero.
    return (sel == sel_hi) ? sh_hi_reg : sh_lo_reg;
  endfunction

  // Shadow model, updated from the inputs seen at each rising edge.
  always @(posedge mclk) begin
    if (reset) begin
      sh_hi_held <= '0;
      sh_lo_held <= '0;
      sh_hi_reg  <= '0;
      sh_lo_reg  <= '0;
    end else begin
      if (sample) begin
        sh_hi_held <= ref_encode(req[15:8]);
        sh_lo_held <= ref_encode(req[7:0]);
      end
      if (bus_wr.wr && bus_wr.sel == sel_hi) sh_hi_reg <= bus_wr.data;  // write beats grant.
      else if (grant_hi) sh_hi_reg.level <= sh_hi_held.vec;
      if (bus_wr.wr && bus_wr.sel == sel_lo) sh_lo_reg <= bus_wr.data;
      else if (grant_lo) sh_lo_reg.level <= sh_lo_held.vec;
    end
  end

  task automatic check_held(held_vec_t got, held_vec_t exp, string what);
    checks++;
    if (got !== exp) begin
      held_errs++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_level(level_reg_t got, level_reg_t exp, string what);
    checks++;
    if (got !== exp) begin
      level_errs++;
      $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    checks++;
    if (got !== exp) begin
      flag_errs++;
      $display("Fail at %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Outputs are settled by the falling edge, half a cycle after any change.
  always @(negedge mclk) begin
    if (!reset) begin
      check_held(hi_held, sh_hi_held, "hi_held");
      check_held(lo_held, sh_lo_held, "lo_held");
      check_flag(hi_above, ref_above(sh_hi_held, sh_hi_reg), "hi_above");
      check_flag(lo_above, ref_above(sh_lo_held, sh_lo_reg), "lo_above");
      check_level(rd_data, ref_read(rd_en, rd_sel), "rd_data");
    end
  end

  task automatic next_cycle();
    @(posedge mclk);
    #1;  // inputs change 1 ns after the edge.
  endtask

  task automatic pulse_sample(req_t r);
    req    = r;
    sample = 1'b1;
    next_cycle();
    sample = 1'b0;
  endtask

  task automatic write_reg(group_sel_t sel, level_reg_t data);
    bus_wr = '{wr: 1'b1, sel: sel, data: data};
    next_cycle();
    bus_wr = '0;
  endtask

  task automatic read_reg(group_sel_t sel);
    rd_en  = 1'b1;
    rd_sel = sel;
    next_cycle();
    rd_en = 1'b0;  // the idle cycle checks the zero readback.
    next_cycle();
  endtask

  // Waits for both held detect flags, giving up after wait_limit cycles.
  task automatic wait_held_det(output logic ok);
    ok = 1'b0;
    for (int n = 0; n < wait_limit && !ok; n++) begin
      if (hi_held.det && lo_held.det) ok = 1'b1;
      else next_cycle();
    end
    if (!ok) begin
      timeouts++;
      $display("Timeout: held detect flags did not both go high after a sample.");
    end
  endtask

  initial begin
    lfsr_state = lfsr_seed;
    {checks, held_errs, level_errs, flag_errs, timeouts} = '0;
    reset    = 1'b1;
    sample   = 1'b0;
    grant_hi = 1'b0;
    grant_lo = 1'b0;
    rd_en    = 1'b0;
    rd_sel   = sel_lo;
    req      = '0;
    bus_wr   = '0;
    repeat (3) @(posedge mclk);
    #1 reset = 1'b0;
    read_reg(sel_lo);  // both groups read back zero after reset.
    read_reg(sel_hi);
    pulse_sample('0);  // idle groups.
    for (int i = 0; i < num_req; i++) pulse_sample(req_t'(1) << i);  // one line at a time.
    for (int n = 0; n < 40; n++) begin
      req = rand_req();
      if (n % 4 == 0) req[15:8] = '0;  // some rounds leave a group idle.
      if (n % 4 == 1) req[7:0] = '0;
      pulse_sample(req);
    end
    for (int n = 0; n < 10; n++) begin
      req = rand_req();  // no sample, so the held values must not move.
      next_cycle();
    end
    for (int n = 0; n < 20; n++) begin
      rd_sel = (take_bits(1) == 1) ? sel_hi : sel_lo;
      write_reg(rd_sel, rand_level());
      read_reg(sel_hi);
      read_reg(sel_lo);
    end
    for (int n = 0; n < 30; n++) begin
      pulse_sample(rand_req());
      write_reg(sel_hi, rand_level());
      write_reg(sel_lo, rand_level());
      write_reg(sel_hi, '{enable: 1'b1, level: sh_hi_held.vec});  // equal level case.
      write_reg(sel_lo, '{enable: 1'b0, level: '0});              // disabled case.
      next_cycle();
    end
    for (int n = 0; n < 10; n++) begin
      req = rand_req();
      req[8 + take_bits(3)] = 1'b1;  // both groups get at least one pending line.
      req[take_bits(3)]     = 1'b1;
      pulse_sample(req);
      wait_held_det(det_ok);
      if (det_ok) begin
        write_reg(sel_hi, rand_level());
        grant_hi = 1'b1;
        grant_lo = 1'b1;
        next_cycle();
        grant_hi = 1'b0;
        grant_lo = 1'b0;
        read_reg(sel_hi);
        read_reg(sel_lo);
        bus_wr   = '{wr: 1'b1, sel: sel_lo, data: rand_level()};
        grant_lo = 1'b1;  // write and grant hit the low group together.
        next_cycle();
        bus_wr   = '0;
        grant_lo = 1'b0;
        read_reg(sel_lo);
      end
    end
    next_cycle();
    $display("checks %0d, held errors %0d, level errors %0d, flag errors %0d, timeouts %0d",
             checks, held_errs, level_errs, flag_errs, timeouts);
    if (held_errs + level_errs + flag_errs + timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
verilog/intr_types_pkg.sv
verilog/intr_bus_pkg.sv
verilog/req_priority.sv
verilog/vector_hold.sv
verilog/level_status.sv
verilog/intr_vecgen.sv
verification/tb_intr_vecgen.sv

// ==== Bender.yml ====
package:
  name: intr_vecgen

sources:
  # Packages first, the bus package uses the request types.
  - verilog/intr_types_pkg.sv
  - verilog/intr_bus_pkg.sv
  # Design modules, leaves before the top level.
  - verilog/req_priority.sv
  - verilog/vector_hold.sv
  - verilog/level_status.sv
  - verilog/intr_vecgen.sv
  # Testbench, only for simulation.
  - target: simulation
    files:
      - verification/tb_intr_vecgen.sv
